//--- list.f
rs_pkg.sv
alu_pkg.sv
rs_operand_capture.sv
rs_entry_table.sv
rs_issue_select.sv
rs_alu.sv
rs_top.sv
rs_asserts.sv
tb_rs.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rs
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_rs.sv
/*
 * testbench for the ALU reservation station
 *   clock, reset, stimulus tasks and reference ALU model
 *   scoreboard with compare process, watchdog and reporting
 */

`default_nettype none

module tb_rs;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clock_period = 20;
    localparam int num_tags = 2 ** rs_pkg::tag_width;
    localparam int num_dispatches = 230;
    localparam int watchdog_ns = num_dispatches * 40 * clock_period + 4000;
    localparam int src_unused = 0;
    localparam int src_reg = 1;
    localparam int src_rob = 2;
    localparam int src_wait = 3;

    logic                         clock;
    logic                         reset;
    logic                         squash;
    logic                         dispatch;
    alu_pkg::alu_op_t             opcode;
    logic [rs_pkg::tag_width-1:0] dest_tag;
    logic                         src0_req;
    logic [rs_pkg::tag_width-1:0] src0_tag;
    logic                         src0_map_ready;
    logic [rs_pkg::xlen-1:0]      src0_reg_value;
    logic [rs_pkg::xlen-1:0]      src0_rob_value;
    logic                         src1_req;
    logic [rs_pkg::tag_width-1:0] src1_tag;
    logic                         src1_map_ready;
    logic [rs_pkg::xlen-1:0]      src1_reg_value;
    logic [rs_pkg::xlen-1:0]      src1_rob_value;
    logic                         cdb_valid;
    logic [rs_pkg::tag_width-1:0] cdb_tag;
    logic [rs_pkg::xlen-1:0]      cdb_value;
    logic                         full;
    logic                         result_valid;
    logic [rs_pkg::tag_width-1:0] result_tag;
    logic [rs_pkg::xlen-1:0]      result_value;

    // scoreboard, one slot per destination tag
    int                      disp_count [num_tags];
    int                      res_count  [num_tags];
    alu_pkg::alu_op_t        sb_op      [num_tags];
    logic [rs_pkg::xlen-1:0] sb_a       [num_tags];
    logic [rs_pkg::xlen-1:0] sb_b       [num_tags];
    int                      sb_cycle   [num_tags];
    logic [rs_pkg::xlen-1:0] tag_value  [num_tags];
    logic [rs_pkg::xlen-1:0] expected_value;
    logic [31:0]             rng = 32'h3812;
    int cycle = 0;
    int errors = 0;
    int cmp_errors = 0;
    int tests_ok = 0;
    int tests_bad = 0;

    rs_top #(.num_entries(4)) uut (
        .clock(clock), .reset(reset), .squash(squash), .dispatch(dispatch),
        .opcode(opcode), .dest_tag(dest_tag),
        .src0_req(src0_req), .src0_tag(src0_tag), .src0_map_ready(src0_map_ready),
        .src0_reg_value(src0_reg_value), .src0_rob_value(src0_rob_value),
        .src1_req(src1_req), .src1_tag(src1_tag), .src1_map_ready(src1_map_ready),
        .src1_reg_value(src1_reg_value), .src1_rob_value(src1_rob_value),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .full(full), .result_valid(result_valid), .result_tag(result_tag),
        .result_value(result_value)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;

    initial begin
        #(watchdog_ns);
        $display("watchdog expired at %0t, the run did not reach its end", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////
    // models

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [rs_pkg::xlen-1:0] alu_ref(input alu_pkg::alu_op_t op,
            input logic [rs_pkg::xlen-1:0] a, input logic [rs_pkg::xlen-1:0] b);
        case (op)
            alu_pkg::alu_add: return a + b;
            alu_pkg::alu_sub: return a - b;
            alu_pkg::alu_and: return a & b;
            alu_pkg::alu_or:  return a | b;
            alu_pkg::alu_xor: return a ^ b;
            alu_pkg::alu_sll: return a << b[4:0];
            alu_pkg::alu_srl: return a >> b[4:0];
            default:          return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic bit any_pending();
        for (int t = 0; t < num_tags; t++) begin
            if (disp_count[t] != res_count[t]) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic int total_errors();
        return errors + cmp_errors + uut.u_asserts.violations;
    endfunction

    ////////////////////
    // stimulus

    // wait sources get a wrong ROB value so a bad priority shows up
    task automatic set_source(input int n, input int kind,
                              input logic [rs_pkg::tag_width-1:0] tag,
                              output logic [rs_pkg::xlen-1:0] true_value);
        logic [rs_pkg::xlen-1:0]      rval;
        logic [rs_pkg::xlen-1:0]      robv;
        logic [rs_pkg::tag_width-1:0] mtag;
        rval = next_rand();
        robv = (kind == src_rob) ? tag_value[tag] : ~tag_value[tag];
        mtag = (kind == src_unused || kind == src_reg) ? rs_pkg::zero_tag : tag;
        if (kind == src_unused) true_value = '0;
        else if (kind == src_reg) true_value = rval;
        else true_value = tag_value[tag];
        if (n == 0) begin
            src0_req       <= (kind != src_unused);
            src0_tag       <= mtag;
            src0_map_ready <= (kind == src_rob);
            src0_reg_value <= rval;
            src0_rob_value <= robv;
        end else begin
            src1_req       <= (kind != src_unused);
            src1_tag       <= mtag;
            src1_map_ready <= (kind == src_rob);
            src1_reg_value <= rval;
            src1_rob_value <= robv;
        end
    endtask

    // one clock of stimulus, dispatch accepted when full is low
    task automatic step(input logic disp, input alu_pkg::alu_op_t op, input int dtag,
                        input int kind0, input int tag0, input int kind1, input int tag1,
                        input logic cdb_on, input int ctag);
        logic [rs_pkg::xlen-1:0]      a;
        logic [rs_pkg::xlen-1:0]      b;
        logic [rs_pkg::tag_width-1:0] dt;
        logic [rs_pkg::tag_width-1:0] ct;
        dt = rs_pkg::tag_width'(dtag);
        ct = rs_pkg::tag_width'(ctag);
        @(posedge clock);
        set_source(0, kind0, rs_pkg::tag_width'(tag0), a);
        set_source(1, kind1, rs_pkg::tag_width'(tag1), b);
        squash    <= 1'b0;
        dispatch  <= disp;
        opcode    <= op;
        dest_tag  <= dt;
        cdb_valid <= cdb_on;
        cdb_tag   <= ct;
        cdb_value <= tag_value[ct];
        @(negedge clock);
        if (disp && !full) begin
            disp_count[dt] = disp_count[dt] + 1;
            sb_op[dt]      = op;
            sb_a[dt]       = a;
            sb_b[dt]       = b;
            sb_cycle[dt]   = cycle + 1;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) step(1'b0, alu_pkg::alu_add, 0, src_unused, 0, src_unused, 0, 1'b0, 0);
    endtask

    task automatic broadcast(input int tag);
        step(1'b0, alu_pkg::alu_add, 0, src_unused, 0, src_unused, 0, 1'b1, tag);
    endtask

    task automatic do_squash();
        @(posedge clock);
        squash    <= 1'b1;
        dispatch  <= 1'b0;
        cdb_valid <= 1'b0;
        @(negedge clock);
        for (int t = 0; t < num_tags; t++) disp_count[t] = res_count[t];
    endtask

    task automatic drain(input int max_cycles);
        int n;
        n = 0;
        while (any_pending() && n < max_cycles) begin
            idle(1);
            n++;
        end
        assert (!any_pending()) else begin
            $display("results still missing %0d cycles into the drain", max_cycles);
            errors++;
        end
    endtask

    task automatic check_full(input logic exp);
        assert (full == exp) else begin
            $display("FAIL %0t full expected %b actual %b", $time, exp, full);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int mark);
        if (total_errors() == mark) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, total_errors() - mark);
        end
    endtask

    ////////////////////
    // compare

    always @(negedge clock) begin
        if (result_valid) begin
            assert (disp_count[result_tag] == res_count[result_tag] + 1) else begin
                $display("at %0t a result came for tag %0d with nothing pending",
                         $time, result_tag);
                cmp_errors++;
            end
            if (disp_count[result_tag] == res_count[result_tag] + 1) begin
                expected_value = alu_ref(sb_op[result_tag], sb_a[result_tag],
                                         sb_b[result_tag]);
                assert (result_value == expected_value) else begin
                    $display("FAIL %0t result_value tag %0d expected %h actual %h",
                             $time, result_tag, expected_value, result_value);
                    cmp_errors++;
                end
                assert (cycle - sb_cycle[result_tag] >= 2) else begin
                    $display("result for tag %0d at %0t came sooner than 2 cycles",
                             result_tag, $time);
                    cmp_errors++;
                end
                res_count[result_tag] = res_count[result_tag] + 1;
            end
        end
    end

    ////////////////////
    // tests

    initial begin
        int mark;
        int next_dest;
        logic [31:0] r;
        for (int t = 0; t < num_tags; t++) begin
            disp_count[t] = 0;
            tag_value[t]  = next_rand();
        end
        reset = 1'b1;
        squash = 1'b0;
        dispatch = 1'b0;
        opcode = alu_pkg::alu_add;
        dest_tag = '0;
        src0_req = 1'b0;
        src0_tag = '0;
        src0_map_ready = 1'b0;
        src0_reg_value = '0;
        src0_rob_value = '0;
        src1_req = 1'b0;
        src1_tag = '0;
        src1_map_ready = 1'b0;
        src1_reg_value = '0;
        src1_rob_value = '0;
        cdb_valid = 1'b0;
        cdb_tag = '0;
        cdb_value = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        mark = total_errors();
        for (int i = 0; i < 8; i++) begin
            step(1'b1, alu_pkg::alu_op_t'(3'(i)), 1 + i,
                 (i % 2 == 0) ? src_reg : src_rob, 16 + i,
                 (i % 3 == 0) ? src_unused : ((i % 3 == 1) ? src_reg : src_rob), 23 - i,
                 1'b0, 0);
        end
        drain(40);
        finish_test("independent operands", mark);

        mark = total_errors();
        step(1'b1, alu_pkg::alu_sub, 9, src_wait, 24, src_reg, 0, 1'b0, 0);
        step(1'b1, alu_pkg::alu_slt, 10, src_rob, 17, src_wait, 24, 1'b0, 0);
        idle(6);
        assert (disp_count[9] != res_count[9] && disp_count[10] != res_count[10]) else begin
            $display("a result for tag 9 or 10 came before the CDB broadcast");
            errors++;
        end
        broadcast(24);
        drain(20);
        finish_test("CDB wake-up", mark);

        mark = total_errors();
        step(1'b1, alu_pkg::alu_add, 11, src_wait, 25, src_wait, 25, 1'b1, 25);
        drain(10);
        finish_test("CDB forward at dispatch", mark);

        mark = total_errors();
        for (int i = 1; i <= 4; i++) begin
            step(1'b1, alu_pkg::alu_add, i, src_reg, 0, src_wait, 26, 1'b0, 0);
        end
        step(1'b1, alu_pkg::alu_or, 5, src_reg, 0, src_reg, 0, 1'b0, 0);
        check_full(1'b1);
        broadcast(26);
        drain(20);
        idle(10);
        finish_test("full and drop", mark);

        mark = total_errors();
        for (int i = 6; i <= 9; i++) begin
            step(1'b1, alu_pkg::alu_and, i, src_wait, 27, src_rob, 18, 1'b0, 0);
        end
        idle(1);
        check_full(1'b1);
        do_squash();
        idle(1);
        check_full(1'b0);
        broadcast(27);
        idle(8);
        for (int i = 10; i <= 12; i++) begin
            step(1'b1, alu_pkg::alu_sll, i, src_rob, 19, src_reg, 0, 1'b0, 0);
        end
        drain(20);
        finish_test("squash", mark);

        // waiting sources use tags 16 to 23, broadcast at random
        mark = total_errors();
        next_dest = 1;
        for (int i = 0; i < 200; i++) begin
            r = next_rand();
            while (disp_count[next_dest] != res_count[next_dest]) begin
                next_dest = next_dest % 15 + 1;
            end
            step(1'b1, alu_pkg::alu_op_t'(r[2:0]), next_dest,
                 int'(r[4:3]), int'({2'b10, r[9:7]}), int'(r[6:5]), int'({2'b10, r[12:10]}),
                 r[13], int'({2'b10, r[16:14]}));
            next_dest = next_dest % 15 + 1;
        end
        for (int t = 16; t < 24; t++) broadcast(t);
        drain(200);
        finish_test("random mix", mark);

        $display("tests ok %0d, tests with errors %0d, errors %0d",
                 tests_ok, tests_bad, total_errors());
        if (total_errors() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rs_asserts.sv
/*
 * concurrent checks bound into the reservation station top level
 *   result_valid low after reset, nonzero result tag, full low after squash
 */

`default_nettype none

module rs_asserts (
    input wire logic                         clock,
    input wire logic                         reset,
    input wire logic                         squash,
    input wire logic                         full,
    input wire logic                         result_valid,
    input wire logic [rs_pkg::tag_width-1:0] result_tag
);

    timeunit 1ns;
    timeprecision 1ps;

    int violations = 0;

    result_idle_after_reset: assert property (@(posedge clock) reset |=> !result_valid)
        else begin
            $error("result_valid high in the cycle after reset");
            violations++;
        end

    // tag 0 is never a destination
    result_tag_nonzero: assert property (@(posedge clock) disable iff (reset)
        result_valid |-> result_tag != rs_pkg::zero_tag)
        else begin
            $error("result broadcast with the zero tag");
            violations++;
        end

    full_low_after_squash: assert property (@(posedge clock) squash |=> !full)
        else begin
            $error("full still high in the cycle after squash");
            violations++;
        end

endmodule

bind rs_top rs_asserts u_asserts (
    .clock(clock), .reset(reset), .squash(squash), .full(full),
    .result_valid(result_valid), .result_tag(result_tag)
);

`default_nettype wire

//--- rs_top.sv
/*
 * ALU reservation station top level
 *   capture, entry table, issue select and execute stage
 */

`default_nettype none

module rs_top #(
    parameter int num_entries = 4
) (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         squash,
    input  wire logic                         dispatch,
    input  wire alu_pkg::alu_op_t             opcode,
    input  wire logic [rs_pkg::tag_width-1:0] dest_tag,
    input  wire logic                         src0_req,
    input  wire logic [rs_pkg::tag_width-1:0] src0_tag,
    input  wire logic                         src0_map_ready,
    input  wire logic [rs_pkg::xlen-1:0]      src0_reg_value,
    input  wire logic [rs_pkg::xlen-1:0]      src0_rob_value,
    input  wire logic                         src1_req,
    input  wire logic [rs_pkg::tag_width-1:0] src1_tag,
    input  wire logic                         src1_map_ready,
    input  wire logic [rs_pkg::xlen-1:0]      src1_reg_value,
    input  wire logic [rs_pkg::xlen-1:0]      src1_rob_value,
    input  wire logic                         cdb_valid,
    input  wire logic [rs_pkg::tag_width-1:0] cdb_tag,
    input  wire logic [rs_pkg::xlen-1:0]      cdb_value,
    output logic                              full,
    output logic                              result_valid,
    output logic      [rs_pkg::tag_width-1:0] result_tag,
    output logic      [rs_pkg::xlen-1:0]      result_value
);

    logic [rs_pkg::xlen-1:0]      src0_value;
    logic                         src0_ready;
    logic [rs_pkg::tag_width-1:0] src0_wait_tag;
    logic [rs_pkg::xlen-1:0]      src1_value;
    logic                         src1_ready;
    logic [rs_pkg::tag_width-1:0] src1_wait_tag;

    logic [num_entries-1:0]       ready;
    logic [num_entries-1:0]       grant;
    alu_pkg::alu_op_t             entry_op  [num_entries];
    logic [rs_pkg::tag_width-1:0] entry_tag [num_entries];
    logic [rs_pkg::xlen-1:0]      entry_a   [num_entries];
    logic [rs_pkg::xlen-1:0]      entry_b   [num_entries];

    logic                         issue_valid;
    alu_pkg::alu_op_t             issue_op;
    logic [rs_pkg::tag_width-1:0] issue_tag;
    logic [rs_pkg::xlen-1:0]      issue_a;
    logic [rs_pkg::xlen-1:0]      issue_b;

    rs_operand_capture u_capture (
        .src0_req(src0_req), .src0_tag(src0_tag), .src0_map_ready(src0_map_ready),
        .src0_reg_value(src0_reg_value), .src0_rob_value(src0_rob_value),
        .src1_req(src1_req), .src1_tag(src1_tag), .src1_map_ready(src1_map_ready),
        .src1_reg_value(src1_reg_value), .src1_rob_value(src1_rob_value),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .src0_value(src0_value), .src0_ready(src0_ready), .src0_wait_tag(src0_wait_tag),
        .src1_value(src1_value), .src1_ready(src1_ready), .src1_wait_tag(src1_wait_tag)
    );

    rs_entry_table #(.num_entries(num_entries)) u_table (
        .clock(clock), .reset(reset), .squash(squash),
        .dispatch(dispatch), .opcode(opcode), .dest_tag(dest_tag),
        .src0_value(src0_value), .src0_ready(src0_ready), .src0_wait_tag(src0_wait_tag),
        .src1_value(src1_value), .src1_ready(src1_ready), .src1_wait_tag(src1_wait_tag),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .grant(grant), .ready(ready),
        .entry_op(entry_op), .entry_tag(entry_tag), .entry_a(entry_a), .entry_b(entry_b),
        .full(full)
    );

    rs_issue_select #(.num_entries(num_entries)) u_select (
        .clock(clock), .reset(reset), .squash(squash), .ready(ready),
        .entry_op(entry_op), .entry_tag(entry_tag), .entry_a(entry_a), .entry_b(entry_b),
        .grant(grant), .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_tag(issue_tag), .issue_a(issue_a), .issue_b(issue_b)
    );

    rs_alu u_alu (
        .clock(clock), .reset(reset), .squash(squash),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_tag(issue_tag),
        .issue_a(issue_a), .issue_b(issue_b),
        .result_valid(result_valid), .result_tag(result_tag), .result_value(result_value)
    );

endmodule

`default_nettype wire

//--- rs_alu.sv
/*
 * integer ALU execute stage
 *   one-cycle compute, result registered with its tag
 */

`default_nettype none

module rs_alu (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         squash,
    input  wire logic                         issue_valid,
    input  wire alu_pkg::alu_op_t             issue_op,
    input  wire logic [rs_pkg::tag_width-1:0] issue_tag,
    input  wire logic [rs_pkg::xlen-1:0]      issue_a,
    input  wire logic [rs_pkg::xlen-1:0]      issue_b,
    output logic                              result_valid,
    output logic      [rs_pkg::tag_width-1:0] result_tag,
    output logic      [rs_pkg::xlen-1:0]      result_value
);

    logic [rs_pkg::xlen-1:0] alu_out;
    logic [4:0]              shamt;

    // shifts use the low 5 bits of operand 1
    assign shamt = issue_b[4:0];

    always_comb begin
        case (issue_op)
            alu_pkg::alu_add: alu_out = issue_a + issue_b;
            alu_pkg::alu_sub: alu_out = issue_a - issue_b;
            alu_pkg::alu_and: alu_out = issue_a & issue_b;
            alu_pkg::alu_or:  alu_out = issue_a | issue_b;
            alu_pkg::alu_xor: alu_out = issue_a ^ issue_b;
            alu_pkg::alu_sll: alu_out = issue_a << shamt;
            alu_pkg::alu_srl: alu_out = issue_a >> shamt;
            alu_pkg::alu_slt: alu_out = rs_pkg::xlen'($signed(issue_a) < $signed(issue_b));
            default:          alu_out = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            result_tag   <= issue_tag;
            result_value <= alu_out;
        end
    end

endmodule

`default_nettype wire

//--- rs_issue_select.sv
/*
 * issue select
 *   fixed-priority grant of the lowest ready entry
 *   issue register feeding the ALU stage
 */

`default_nettype none

module rs_issue_select #(
    parameter int num_entries = 4
) (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         squash,
    input  wire logic [num_entries-1:0]       ready,
    input  wire alu_pkg::alu_op_t             entry_op  [num_entries],
    input  wire logic [rs_pkg::tag_width-1:0] entry_tag [num_entries],
    input  wire logic [rs_pkg::xlen-1:0]      entry_a   [num_entries],
    input  wire logic [rs_pkg::xlen-1:0]      entry_b   [num_entries],
    output logic      [num_entries-1:0]       grant,
    output logic                              issue_valid,
    output alu_pkg::alu_op_t                  issue_op,
    output logic      [rs_pkg::tag_width-1:0] issue_tag,
    output logic      [rs_pkg::xlen-1:0]      issue_a,
    output logic      [rs_pkg::xlen-1:0]      issue_b
);

    localparam int entry_index_width = $clog2(num_entries);

    logic [entry_index_width-1:0] sel_idx;
    logic                         sel_any;

    // lowest index wins
    always_comb begin
        sel_any = 1'b0;
        sel_idx = '0;
        grant   = '0;
        for (int i = 0; i < num_entries; i++) begin
            if (!sel_any && ready[i]) begin
                sel_any  = 1'b1;
                sel_idx  = entry_index_width'(i);
                grant[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= sel_any;
        end
    end

    always_ff @(posedge clock) begin
        if (sel_any) begin
            issue_op  <= entry_op[sel_idx];
            issue_tag <= entry_tag[sel_idx];
            issue_a   <= entry_a[sel_idx];
            issue_b   <= entry_b[sel_idx];
        end
    end

endmodule

`default_nettype wire

//--- rs_entry_table.sv
/*
 * reservation station entry storage
 *   busy flags, lowest-free allocation, CDB wake-up
 *   freeing of granted entries and the registered full flag
 */

`default_nettype none

module rs_entry_table #(
    parameter int num_entries = 4
) (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         squash,
    input  wire logic                         dispatch,
    input  wire alu_pkg::alu_op_t             opcode,
    input  wire logic [rs_pkg::tag_width-1:0] dest_tag,
    input  wire logic [rs_pkg::xlen-1:0]      src0_value,
    input  wire logic                         src0_ready,
    input  wire logic [rs_pkg::tag_width-1:0] src0_wait_tag,
    input  wire logic [rs_pkg::xlen-1:0]      src1_value,
    input  wire logic                         src1_ready,
    input  wire logic [rs_pkg::tag_width-1:0] src1_wait_tag,
    input  wire logic                         cdb_valid,
    input  wire logic [rs_pkg::tag_width-1:0] cdb_tag,
    input  wire logic [rs_pkg::xlen-1:0]      cdb_value,
    input  wire logic [num_entries-1:0]       grant,
    output logic      [num_entries-1:0]       ready,
    output alu_pkg::alu_op_t                  entry_op  [num_entries],
    output logic      [rs_pkg::tag_width-1:0] entry_tag [num_entries],
    output logic      [rs_pkg::xlen-1:0]      entry_a   [num_entries],
    output logic      [rs_pkg::xlen-1:0]      entry_b   [num_entries],
    output logic                              full
);

    logic [num_entries-1:0]       busy;
    logic [num_entries-1:0]       busy_next;
    logic [num_entries-1:0]       alloc_onehot;
    logic                         alloc_found;
    logic                         accept;

    logic [rs_pkg::xlen-1:0]      cap_value [rs_pkg::num_sources];
    logic                         cap_ready [rs_pkg::num_sources];
    logic [rs_pkg::tag_width-1:0] cap_tag   [rs_pkg::num_sources];

    logic [rs_pkg::xlen-1:0]      val  [num_entries][rs_pkg::num_sources];
    logic                         rdy  [num_entries][rs_pkg::num_sources];
    logic [rs_pkg::tag_width-1:0] wtag [num_entries][rs_pkg::num_sources];

    assign cap_value = '{src0_value, src1_value};
    assign cap_ready = '{src0_ready, src1_ready};
    assign cap_tag   = '{src0_wait_tag, src1_wait_tag};

    ////////////////////
    // allocation

    // a slot granted this cycle counts as free
    always_comb begin
        alloc_found  = 1'b0;
        alloc_onehot = '0;
        for (int i = 0; i < num_entries; i++) begin
            if (!alloc_found && (!busy[i] || grant[i])) begin
                alloc_found     = 1'b1;
                alloc_onehot[i] = 1'b1;
            end
        end
    end

    assign accept    = dispatch && !full && alloc_found;
    assign busy_next = (busy & ~grant) | (accept ? alloc_onehot : '0);

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            busy <= '0;
            full <= 1'b0;
        end else begin
            busy <= busy_next;
            full <= &busy_next;
        end
    end

    ////////////////////
    // entry fields

    always_ff @(posedge clock) begin
        for (int i = 0; i < num_entries; i++) begin
            if (accept && alloc_onehot[i]) begin
                entry_op[i]  <= opcode;
                entry_tag[i] <= dest_tag;
                for (int s = 0; s < rs_pkg::num_sources; s++) begin
                    val[i][s]  <= cap_value[s];
                    rdy[i][s]  <= cap_ready[s];
                    wtag[i][s] <= cap_tag[s];
                end
            end else if (busy[i] && cdb_valid) begin
                // wake-up of waiting operands
                for (int s = 0; s < rs_pkg::num_sources; s++) begin
                    if (!rdy[i][s] && wtag[i][s] == cdb_tag) begin
                        val[i][s] <= cdb_value;
                        rdy[i][s] <= 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < num_entries; i++) begin
            ready[i]   = busy[i] && rdy[i][0] && rdy[i][1];
            entry_a[i] = val[i][0];
            entry_b[i] = val[i][1];
        end
    end

endmodule

`default_nettype wire

//--- rs_operand_capture.sv
/*
 * dispatch-time operand capture
 *   picks value, ready flag and wait tag for both sources
 */

`default_nettype none

module rs_operand_capture (
    input  wire logic                         src0_req,
    input  wire logic [rs_pkg::tag_width-1:0] src0_tag,
    input  wire logic                         src0_map_ready,
    input  wire logic [rs_pkg::xlen-1:0]      src0_reg_value,
    input  wire logic [rs_pkg::xlen-1:0]      src0_rob_value,
    input  wire logic                         src1_req,
    input  wire logic [rs_pkg::tag_width-1:0] src1_tag,
    input  wire logic                         src1_map_ready,
    input  wire logic [rs_pkg::xlen-1:0]      src1_reg_value,
    input  wire logic [rs_pkg::xlen-1:0]      src1_rob_value,
    input  wire logic                         cdb_valid,
    input  wire logic [rs_pkg::tag_width-1:0] cdb_tag,
    input  wire logic [rs_pkg::xlen-1:0]      cdb_value,
    output logic      [rs_pkg::xlen-1:0]      src0_value,
    output logic                              src0_ready,
    output logic      [rs_pkg::tag_width-1:0] src0_wait_tag,
    output logic      [rs_pkg::xlen-1:0]      src1_value,
    output logic                              src1_ready,
    output logic      [rs_pkg::tag_width-1:0] src1_wait_tag
);

    logic                         req       [rs_pkg::num_sources];
    logic [rs_pkg::tag_width-1:0] map_tag   [rs_pkg::num_sources];
    logic                         map_ready [rs_pkg::num_sources];
    logic [rs_pkg::xlen-1:0]      reg_value [rs_pkg::num_sources];
    logic [rs_pkg::xlen-1:0]      rob_value [rs_pkg::num_sources];
    logic [rs_pkg::xlen-1:0]      cap_value [rs_pkg::num_sources];
    logic                         cap_ready [rs_pkg::num_sources];
    logic [rs_pkg::tag_width-1:0] cap_tag   [rs_pkg::num_sources];

    assign req       = '{src0_req, src1_req};
    assign map_tag   = '{src0_tag, src1_tag};
    assign map_ready = '{src0_map_ready, src1_map_ready};
    assign reg_value = '{src0_reg_value, src1_reg_value};
    assign rob_value = '{src0_rob_value, src1_rob_value};

    // priority: unused, register file, CDB forward, ROB, wait
    always_comb begin
        for (int s = 0; s < rs_pkg::num_sources; s++) begin
            cap_value[s] = rob_value[s];
            cap_ready[s] = 1'b1;
            cap_tag[s]   = map_tag[s];
            if (!req[s]) begin
                cap_value[s] = '0;
                cap_tag[s]   = rs_pkg::zero_tag;
            end else if (map_tag[s] == rs_pkg::zero_tag) begin
                cap_value[s] = reg_value[s];
            end else if (cdb_valid && cdb_tag == map_tag[s]) begin
                cap_value[s] = cdb_value;
            end else if (!map_ready[s]) begin
                cap_ready[s] = 1'b0;
            end
        end
    end

    assign src0_value    = cap_value[0];
    assign src0_ready    = cap_ready[0];
    assign src0_wait_tag = cap_tag[0];
    assign src1_value    = cap_value[1];
    assign src1_ready    = cap_ready[1];
    assign src1_wait_tag = cap_tag[1];

endmodule

`default_nettype wire

//--- alu_pkg.sv
/*
 * integer ALU opcode encoding
 */

`default_nettype none

package alu_pkg;

    localparam int alu_op_width = 3;

    typedef enum logic [alu_op_width-1:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5,
        alu_srl = 3'd6,
        alu_slt = 3'd7
    } alu_op_t;

endpackage

`default_nettype wire

//--- rs_pkg.sv
/*
 * reservation station shared constants
 *   datapath and ROB tag widths
 *   zero tag for register-file operands
 *   operand count per entry
 */

`default_nettype none

package rs_pkg;

    ////////////////////
    // datapath

    localparam int xlen = 32;

    ////////////////////
    // ROB tags

    localparam int tag_width = 5;

    // value lives in the register file, always ready
    localparam logic [tag_width-1:0] zero_tag = '0;

    // two source operands per instruction
    localparam int num_sources = 2;

endpackage

`default_nettype wire
